// File: common/peri_pkg.sv
// ------------------------------------------------
// peripheral bus types, address map, register
// offsets and the byte-lane write helper
// ------------------------------------------------

package peri_pkg;

	// ------------------------------------------------
	// bus types
	// ------------------------------------------------

	// word address, byte address bits 31:2
	typedef logic [29:0] peri_adr_t;
	typedef logic [31:0] peri_dat_t;
	typedef logic [3:0]  peri_sel_t;

	// register index inside a block, byte address bits 3:2
	typedef logic [1:0]  peri_ofs_t;

	typedef logic [3:0]  gpio_t;

	// bit 0 timer, bits 1 and 2 external
	typedef logic [2:0]  irq_vec_t;
	typedef logic [1:0]  irq_id_t;

	typedef struct packed {
		peri_adr_t adr;
		peri_dat_t dat;
		logic      we;
		peri_sel_t sel;
		logic      stb;
	} peri_req_t;

	typedef struct packed {
		peri_dat_t dat;
		logic      ack;
	} peri_rsp_t;

	// ------------------------------------------------
	// address map
	// ------------------------------------------------

	localparam int PERI_DEV_NUM = 4;

	localparam int DEV_IRC    = 0;
	localparam int DEV_TIMER  = 1;
	localparam int DEV_GPIO_A = 2;
	localparam int DEV_GPIO_B = 3;

	// compared with byte address bits 31:24
	localparam logic [7:0] ADR_IRC_TOP   = 8'hf0;
	localparam logic [7:0] ADR_TIMER_TOP = 8'hf1;

	// gpio blocks share a top byte, bits 31:8 select
	localparam logic [31:0] ADR_GPIO_A = 32'hf300_0000;
	localparam logic [31:0] ADR_GPIO_B = 32'hf300_0100;

	// ------------------------------------------------
	// register offsets
	// ------------------------------------------------

	localparam peri_ofs_t TMR_CTRL    = 2'd0;
	localparam peri_ofs_t TMR_COMPARE = 2'd1;
	localparam peri_ofs_t TMR_COUNT   = 2'd2;

	localparam peri_ofs_t IRC_ENABLE    = 2'd0;
	localparam peri_ofs_t IRC_PENDING   = 2'd1;
	localparam peri_ofs_t IRC_FACTOR_ID = 2'd2;

	localparam peri_ofs_t GPIO_DIR = 2'd0;
	localparam peri_ofs_t GPIO_OUT = 2'd1;
	localparam peri_ofs_t GPIO_IN  = 2'd2;

	// factor id with nothing enabled and pending
	localparam irq_id_t IRC_NO_FACTOR = 2'd3;

	// replace only the byte lanes whose enable is set
	function automatic peri_dat_t write_bytes(input peri_dat_t old_dat,
			input peri_dat_t new_dat, input peri_sel_t sel);
		peri_dat_t result;
		result = old_dat;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				result[8*i +: 8] = new_dat[8*i +: 8];
			end
		end
		return result;
	endfunction

endpackage

// File: verilog/peri_bus_decoder.sv
// ------------------------------------------------
// peripheral bus address decoder
// fans the request out to every slot and merges
// the matching slot's response
// ------------------------------------------------

`timescale 1ns/1ps

module peri_bus_decoder (
	input  peri_pkg::peri_req_t                          req_i,
	output peri_pkg::peri_req_t [peri_pkg::PERI_DEV_NUM-1:0] dev_req_o,
	input  peri_pkg::peri_rsp_t [peri_pkg::PERI_DEV_NUM-1:0] dev_rsp_i,
	output peri_pkg::peri_rsp_t                          rsp_o
);

	import peri_pkg::*;

	// one bit per slot, set when the address falls in its window
	logic [PERI_DEV_NUM-1:0] adr_hit;

	// ------------------------------------------------
	// address match
	// ------------------------------------------------

	// word address bits 29:22 are byte address bits 31:24
	always_comb begin
		adr_hit             = '0;
		adr_hit[DEV_IRC]    = (req_i.adr[29:22] == ADR_IRC_TOP);
		adr_hit[DEV_TIMER]  = (req_i.adr[29:22] == ADR_TIMER_TOP);
		// gpio windows are 256 bytes wide
		adr_hit[DEV_GPIO_A] = (req_i.adr[29:6] == ADR_GPIO_A[31:8]);
		adr_hit[DEV_GPIO_B] = (req_i.adr[29:6] == ADR_GPIO_B[31:8]);
	end

	// ------------------------------------------------
	// request fan-out
	// ------------------------------------------------

	always_comb begin
		for (int i = 0; i < PERI_DEV_NUM; i++) begin
			dev_req_o[i]     = req_i;
			dev_req_o[i].stb = req_i.stb & adr_hit[i];
		end
	end

	// ------------------------------------------------
	// response merge
	// ------------------------------------------------

	// unmapped access acks right away with zero data
	always_comb begin
		rsp_o.dat = '0;
		rsp_o.ack = req_i.stb;
		for (int i = 0; i < PERI_DEV_NUM; i++) begin
			if (adr_hit[i]) begin
				rsp_o = dev_rsp_i[i];
			end
		end
	end

endmodule

// File: verilog/peri_timer.sv
// ------------------------------------------------
// interval timer
// free counter with compare match, wraps to zero
// and pulses an interrupt on each match
// ------------------------------------------------

`timescale 1ns/1ps

module peri_timer (
	input  logic                clk,
	input  logic                reset,
	input  peri_pkg::peri_req_t req_i,
	output peri_pkg::peri_rsp_t rsp_o,
	output logic                irq_o
);

	import peri_pkg::*;

	logic      enable;
	peri_dat_t compare;
	peri_dat_t count;

	peri_ofs_t ofs;
	logic      wr_en;
	logic      hit;

	assign ofs   = req_i.adr[1:0];
	assign wr_en = req_i.stb & req_i.we;

	// match cycle, count restarts at the next edge
	assign hit   = enable && (count == compare);
	assign irq_o = hit;

	// ------------------------------------------------
	// registers
	// ------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			enable  <= 1'b0;
			compare <= '0;
			count   <= '0;
		end else begin
			if (enable) begin
				count <= hit ? '0 : count + 1'b1;
			end

			// count is read-only, writes to it are dropped
			if (wr_en) begin
				case (ofs)
					TMR_CTRL: begin
						if (req_i.sel[0]) begin
							enable <= req_i.dat[0];
						end
					end
					TMR_COMPARE: begin
						compare <= write_bytes(compare, req_i.dat, req_i.sel);
					end
					default: ;
				endcase
			end
		end
	end

	// ------------------------------------------------
	// read side
	// ------------------------------------------------

	always_comb begin
		case (ofs)
			TMR_CTRL:    rsp_o.dat = {31'b0, enable};
			TMR_COMPARE: rsp_o.dat = compare;
			TMR_COUNT:   rsp_o.dat = count;
			default:     rsp_o.dat = '0;
		endcase
	end

	// single-cycle access
	assign rsp_o.ack = req_i.stb;

endmodule

// File: verilog/peri_irc.sv
// ------------------------------------------------
// interrupt controller
// pending latch with write-one clear, enable mask
// and fixed-priority factor id
// ------------------------------------------------

`timescale 1ns/1ps

module peri_irc (
	input  logic                clk,
	input  logic                reset,
	input  peri_pkg::peri_req_t req_i,
	output peri_pkg::peri_rsp_t rsp_o,
	input  peri_pkg::irq_vec_t  irq_src_i,
	output logic                cpu_irq_o
);

	import peri_pkg::*;

	irq_vec_t  enable;
	irq_vec_t  pending;
	irq_vec_t  active;
	irq_vec_t  clr;
	irq_id_t   factor_id;

	peri_ofs_t ofs;
	logic      wr_en;

	assign ofs   = req_i.adr[1:0];
	assign wr_en = req_i.stb & req_i.we;

	// ones written to the pending register clear those bits
	assign clr = (wr_en && ofs == IRC_PENDING && req_i.sel[0])
		? req_i.dat[2:0] : '0;

	// ------------------------------------------------
	// pending and enable
	// ------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			enable  <= '0;
			pending <= '0;
		end else begin
			// a source still high wins over a clear
			pending <= (pending & ~clr) | irq_src_i;

			if (wr_en && ofs == IRC_ENABLE && req_i.sel[0]) begin
				enable <= req_i.dat[2:0];
			end
		end
	end

	// ------------------------------------------------
	// cpu request and factor id
	// ------------------------------------------------

	assign active    = pending & enable;
	assign cpu_irq_o = |active;

	// lowest source number has priority
	always_comb begin
		if (active[0]) begin
			factor_id = 2'd0;
		end else if (active[1]) begin
			factor_id = 2'd1;
		end else if (active[2]) begin
			factor_id = 2'd2;
		end else begin
			factor_id = IRC_NO_FACTOR;
		end
	end

	// ------------------------------------------------
	// read side
	// ------------------------------------------------

	always_comb begin
		case (ofs)
			IRC_ENABLE:    rsp_o.dat = {29'b0, enable};
			IRC_PENDING:   rsp_o.dat = {29'b0, pending};
			IRC_FACTOR_ID: rsp_o.dat = {30'b0, factor_id};
			default:       rsp_o.dat = '0;
		endcase
	end

	assign rsp_o.ack = req_i.stb;

endmodule

// File: verilog/peri_gpio.sv
// ------------------------------------------------
// 4-bit gpio block
// direction and output registers, input sampled
// on every clock edge
// ------------------------------------------------

`timescale 1ns/1ps

module peri_gpio (
	input  logic                clk,
	input  logic                reset,
	input  peri_pkg::peri_req_t req_i,
	output peri_pkg::peri_rsp_t rsp_o,
	input  peri_pkg::gpio_t     gpio_i,
	output peri_pkg::gpio_t     gpio_o,
	output peri_pkg::gpio_t     gpio_oe_o
);

	import peri_pkg::*;

	gpio_t     dir;
	gpio_t     out;
	gpio_t     in_q;

	peri_ofs_t ofs;
	logic      wr_en;

	assign ofs   = req_i.adr[1:0];
	assign wr_en = req_i.stb & req_i.we & req_i.sel[0];

	// ------------------------------------------------
	// registers
	// ------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			dir  <= '0;
			out  <= '0;
			in_q <= '0;
		end else begin
			// pin value readable one cycle later
			in_q <= gpio_i;

			if (wr_en && ofs == GPIO_DIR) begin
				dir <= req_i.dat[3:0];
			end
			if (wr_en && ofs == GPIO_OUT) begin
				out <= req_i.dat[3:0];
			end
		end
	end

	// 1 in dir drives the pin
	assign gpio_oe_o = dir;
	assign gpio_o    = out;

	// upper bits read zero
	always_comb begin
		case (ofs)
			GPIO_DIR: rsp_o.dat = {28'b0, dir};
			GPIO_OUT: rsp_o.dat = {28'b0, out};
			GPIO_IN:  rsp_o.dat = {28'b0, in_q};
			default:  rsp_o.dat = '0;
		endcase
	end

	assign rsp_o.ack = req_i.stb;

endmodule

// File: verilog/peri_subsystem.sv
// ------------------------------------------------
// peripheral subsystem top level
// bus decoder, interrupt controller, timer and
// two gpio blocks
// ------------------------------------------------

`timescale 1ns/1ps

module peri_subsystem (
	input  logic                clk,
	input  logic                reset,

	// peripheral bus
	input  peri_pkg::peri_req_t req_i,
	output peri_pkg::peri_rsp_t rsp_o,

	// interrupts
	input  logic [1:0]          ext_irq_i,
	output logic                cpu_irq_o,

	// gpio pins
	input  peri_pkg::gpio_t     gpio_a_i,
	output peri_pkg::gpio_t     gpio_a_o,
	output peri_pkg::gpio_t     gpio_a_oe_o,
	input  peri_pkg::gpio_t     gpio_b_i,
	output peri_pkg::gpio_t     gpio_b_o,
	output peri_pkg::gpio_t     gpio_b_oe_o
);

	import peri_pkg::*;

	peri_req_t [PERI_DEV_NUM-1:0] dev_req;
	peri_rsp_t [PERI_DEV_NUM-1:0] dev_rsp;
	logic                         timer_irq;

	// ------------------------------------------------
	// bus decode
	// ------------------------------------------------

	peri_bus_decoder u_bus_decoder (
		.req_i     (req_i),
		.dev_req_o (dev_req),
		.dev_rsp_i (dev_rsp),
		.rsp_o     (rsp_o)
	);

	// ------------------------------------------------
	// interrupt controller and timer
	// ------------------------------------------------

	// source 0 timer, sources 1 and 2 external lines
	peri_irc u_irc (
		.clk       (clk),
		.reset     (reset),
		.req_i     (dev_req[DEV_IRC]),
		.rsp_o     (dev_rsp[DEV_IRC]),
		.irq_src_i ({ext_irq_i, timer_irq}),
		.cpu_irq_o (cpu_irq_o)
	);

	peri_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.req_i (dev_req[DEV_TIMER]),
		.rsp_o (dev_rsp[DEV_TIMER]),
		.irq_o (timer_irq)
	);

	// ------------------------------------------------
	// gpio
	// ------------------------------------------------

	peri_gpio u_gpio_a (
		.clk       (clk),
		.reset     (reset),
		.req_i     (dev_req[DEV_GPIO_A]),
		.rsp_o     (dev_rsp[DEV_GPIO_A]),
		.gpio_i    (gpio_a_i),
		.gpio_o    (gpio_a_o),
		.gpio_oe_o (gpio_a_oe_o)
	);

	peri_gpio u_gpio_b (
		.clk       (clk),
		.reset     (reset),
		.req_i     (dev_req[DEV_GPIO_B]),
		.rsp_o     (dev_rsp[DEV_GPIO_B]),
		.gpio_i    (gpio_b_i),
		.gpio_o    (gpio_b_o),
		.gpio_oe_o (gpio_b_oe_o)
	);

endmodule

// File: dv/peri_subsystem_tb.sv
// ------------------------------------------------
// testbench for the peripheral subsystem
// clock, reset, stimulus table, bus loop, checks
// ------------------------------------------------

`timescale 1ns/1ps

module peri_subsystem_tb;

	import peri_pkg::*;

	localparam logic [31:0] IRC_BASE = {ADR_IRC_TOP, 24'h0};
	localparam logic [31:0] TMR_BASE = {ADR_TIMER_TOP, 24'h0};
	localparam int          TMR_N    = 10;

	typedef enum logic [3:0] {
		OP_WR, OP_RD, OP_RD_LE, OP_PINS, OP_EXT, OP_WAIT,
		OP_WAIT_IRQ, OP_CHK_IRQ, OP_CHK_GPIO
	} op_t;

	typedef struct packed {
		logic [7:0]  test;
		op_t         op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic [31:0] exp;
	} entry_t;

	logic      clk;
	logic      reset;
	peri_req_t req;
	peri_rsp_t rsp;
	logic [1:0] ext_irq;
	logic      cpu_irq;
	gpio_t     gpio_a_in, gpio_a_out, gpio_a_oe;
	gpio_t     gpio_b_in, gpio_b_out, gpio_b_oe;

	entry_t    table_q[$];
	entry_t    e;
	string     test_name[1:5];
	int        cur_test;
	int        test_errors;
	int        error_count;
	int        check_count;

	peri_subsystem u_peri_subsystem (
		.clk         (clk),
		.reset       (reset),
		.req_i       (req),
		.rsp_o       (rsp),
		.ext_irq_i   (ext_irq),
		.cpu_irq_o   (cpu_irq),
		.gpio_a_i    (gpio_a_in),
		.gpio_a_o    (gpio_a_out),
		.gpio_a_oe_o (gpio_a_oe),
		.gpio_b_i    (gpio_b_in),
		.gpio_b_o    (gpio_b_out),
		.gpio_b_oe_o (gpio_b_oe)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------
	// table building
	// ------------------------------------------------

	task automatic add_entry(input int test, input op_t op, input logic [31:0] adr,
			input logic [31:0] dat, input logic [3:0] sel, input logic [31:0] exp);
		entry_t t;
		t.test = test;
		t.op   = op;
		t.adr  = adr;
		t.dat  = dat;
		t.sel  = sel;
		t.exp  = exp;
		table_q.push_back(t);
	endtask

	task automatic add_read(input int test, input logic [31:0] adr, input logic [31:0] exp);
		add_entry(test, OP_RD, adr, 32'h0, 4'hf, exp);
	endtask

	task automatic add_write(input int test, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		add_entry(test, OP_WR, adr, dat, sel, 32'h0);
	endtask

	task automatic build_table();
		logic [31:0] dir_a, out_a, dir_b, out_b, pins;
		logic [31:0] unmapped [6] = '{32'h0000_0000, 32'hf200_0004, 32'hf300_0200,
			32'hf300_1000, 32'hf3ff_fffc, 32'hffff_fffc};
		// reset state
		add_entry(1, OP_CHK_GPIO, 0, 0, 0, 32'h0);
		add_entry(1, OP_CHK_IRQ, 0, 0, 0, 32'h0);
		add_read(1, TMR_BASE + 4*TMR_CTRL, 0);
		add_read(1, TMR_BASE + 4*TMR_COMPARE, 0);
		add_read(1, IRC_BASE + 4*IRC_ENABLE, 0);
		add_read(1, IRC_BASE + 4*IRC_PENDING, 0);
		add_read(1, IRC_BASE + 4*IRC_FACTOR_ID, 3);
		add_read(1, ADR_GPIO_A + 4*GPIO_DIR, 0);
		add_read(1, ADR_GPIO_A + 4*GPIO_OUT, 0);
		add_read(1, ADR_GPIO_B + 4*GPIO_DIR, 0);
		add_read(1, ADR_GPIO_B + 4*GPIO_OUT, 0);
		// gpio registers keep only the low nibble
		dir_a = $urandom;
		out_a = $urandom;
		dir_b = $urandom;
		out_b = $urandom;
		add_write(2, ADR_GPIO_A + 4*GPIO_DIR, dir_a, 4'hf);
		add_write(2, ADR_GPIO_A + 4*GPIO_OUT, out_a, 4'hf);
		add_write(2, ADR_GPIO_B + 4*GPIO_DIR, dir_b, 4'hf);
		add_write(2, ADR_GPIO_B + 4*GPIO_OUT, out_b, 4'hf);
		add_entry(2, OP_CHK_GPIO, 0, 0, 0,
			{16'h0, dir_b[3:0], out_b[3:0], dir_a[3:0], out_a[3:0]});
		add_read(2, ADR_GPIO_A + 4*GPIO_DIR, {28'h0, dir_a[3:0]});
		add_read(2, ADR_GPIO_A + 4*GPIO_OUT, {28'h0, out_a[3:0]});
		add_read(2, ADR_GPIO_B + 4*GPIO_DIR, {28'h0, dir_b[3:0]});
		add_read(2, ADR_GPIO_B + 4*GPIO_OUT, {28'h0, out_b[3:0]});
		// nothing may change with the low byte lane off
		add_write(2, ADR_GPIO_A + 4*GPIO_DIR, ~dir_a, 4'h0);
		add_write(2, ADR_GPIO_B + 4*GPIO_OUT, ~out_b, 4'he);
		add_read(2, ADR_GPIO_A + 4*GPIO_DIR, {28'h0, dir_a[3:0]});
		add_read(2, ADR_GPIO_B + 4*GPIO_OUT, {28'h0, out_b[3:0]});
		for (int r = 0; r < 3; r++) begin
			pins = $urandom;
			add_entry(2, OP_PINS, 0, {24'h0, pins[7:0]}, 0, 0);
			add_read(2, ADR_GPIO_A + 4*GPIO_IN, {28'h0, pins[3:0]});
			add_read(2, ADR_GPIO_B + 4*GPIO_IN, {28'h0, pins[7:4]});
		end
		// unmapped space acks at once and reads zero
		foreach (unmapped[i]) begin
			add_write(3, unmapped[i], $urandom, 4'hf);
			add_read(3, unmapped[i], 0);
		end
		add_entry(3, OP_CHK_GPIO, 0, 0, 0,
			{16'h0, dir_b[3:0], out_b[3:0], dir_a[3:0], out_a[3:0]});
		add_read(3, ADR_GPIO_A + 4*GPIO_DIR, {28'h0, dir_a[3:0]});
		add_read(3, ADR_GPIO_B + 4*GPIO_OUT, {28'h0, out_b[3:0]});
		add_read(3, TMR_BASE + 4*TMR_CTRL, 0);
		add_read(3, TMR_BASE + 4*TMR_COMPARE, 0);
		add_read(3, IRC_BASE + 4*IRC_ENABLE, 0);
		// timer with period TMR_N + 1 on source 0
		add_write(4, IRC_BASE + 4*IRC_ENABLE, 1, 4'hf);
		add_write(4, TMR_BASE + 4*TMR_COMPARE, TMR_N, 4'hf);
		add_read(4, TMR_BASE + 4*TMR_COMPARE, TMR_N);
		add_write(4, TMR_BASE + 4*TMR_CTRL, 1, 4'hf);
		add_entry(4, OP_WAIT_IRQ, 0, TMR_N + 5, 0, 0);
		add_read(4, IRC_BASE + 4*IRC_PENDING, 1);
		add_write(4, IRC_BASE + 4*IRC_PENDING, 1, 4'hf);
		add_read(4, IRC_BASE + 4*IRC_PENDING, 0);
		add_entry(4, OP_RD_LE, TMR_BASE + 4*TMR_COUNT, 0, 4'hf, TMR_N);
		add_write(4, TMR_BASE + 4*TMR_CTRL, 0, 4'hf);
		add_entry(4, OP_WAIT, 0, 2*TMR_N + 4, 0, 0);
		add_read(4, IRC_BASE + 4*IRC_PENDING, 0);
		add_entry(4, OP_CHK_IRQ, 0, 0, 0, 0);
		// interrupt controller with the external lines
		add_write(5, IRC_BASE + 4*IRC_ENABLE, 0, 4'hf);
		add_entry(5, OP_EXT, 0, 3, 0, 0);
		add_read(5, IRC_BASE + 4*IRC_PENDING, 6);
		add_entry(5, OP_CHK_IRQ, 0, 0, 0, 0);
		add_write(5, IRC_BASE + 4*IRC_ENABLE, 4, 4'hf);
		add_entry(5, OP_CHK_IRQ, 0, 0, 0, 1);
		add_read(5, IRC_BASE + 4*IRC_FACTOR_ID, 2);
		add_write(5, IRC_BASE + 4*IRC_ENABLE, 6, 4'hf);
		add_read(5, IRC_BASE + 4*IRC_FACTOR_ID, 1);
		add_entry(5, OP_EXT, 0, 0, 0, 0);
		add_write(5, IRC_BASE + 4*IRC_PENDING, 6, 4'hf);
		add_entry(5, OP_CHK_IRQ, 0, 0, 0, 0);
		add_read(5, IRC_BASE + 4*IRC_FACTOR_ID, 3);
		add_read(5, IRC_BASE + 4*IRC_PENDING, 0);
	endtask

	// ------------------------------------------------
	// checks
	// ------------------------------------------------

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("[ERROR] test %0d: %s = %h, expected %h",
				cur_test, name, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic wait_irq(input int limit);
		int  n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk);
			#2;
			seen = cpu_irq;
			n++;
		end
		check_count++;
		assert (seen) else begin
			$display("test %0d: cpu_irq_o did not rise within %0d cycles",
				cur_test, limit);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_test(input int n);
		if (test_errors == 0) begin
			$display("test %0d %s: ok", n, test_name[n]);
		end else begin
			$display("test %0d %s: %0d errors", n, test_name[n], test_errors);
		end
	endtask

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------

	initial begin
		reset        = 1'b1;
		req          = '0;
		ext_irq      = '0;
		gpio_a_in    = '0;
		gpio_b_in    = '0;
		cur_test     = 0;
		test_errors  = 0;
		error_count  = 0;
		check_count  = 0;
		test_name[1] = "reset state";
		test_name[2] = "gpio registers";
		test_name[3] = "address decode";
		test_name[4] = "timer";
		test_name[5] = "interrupt controller";
		void'($urandom(59));
		build_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		foreach (table_q[k]) begin
			e = table_q[k];
			if (e.test != cur_test) begin
				if (cur_test != 0) begin
					report_test(cur_test);
				end
				cur_test    = e.test;
				test_errors = 0;
			end
			@(negedge clk);
			req = '0;
			case (e.op)
				OP_WR, OP_RD, OP_RD_LE: begin
					req.adr = e.adr[31:2];
					req.dat = e.dat;
					req.sel = e.sel;
					req.we  = (e.op == OP_WR);
					req.stb = 1'b1;
					#2;
					check_value("rsp_o.ack", rsp.ack, 1);
					if (e.op == OP_RD) begin
						check_value("rsp_o.dat", rsp.dat, e.exp);
					end else if (e.op == OP_RD_LE) begin
						check_count++;
						assert (rsp.dat <= e.exp) else begin
							$display("[ERROR] test %0d: rsp_o.dat = %h, expected at most %h",
								cur_test, rsp.dat, e.exp);
							error_count++;
							test_errors++;
						end
					end
				end
				OP_PINS: begin
					gpio_a_in = e.dat[3:0];
					gpio_b_in = e.dat[7:4];
				end
				OP_EXT:      ext_irq = e.dat[1:0];
				OP_WAIT:     repeat (e.dat) @(negedge clk);
				OP_WAIT_IRQ: wait_irq(e.dat);
				OP_CHK_IRQ: begin
					#2;
					check_value("cpu_irq_o", cpu_irq, e.exp[0]);
				end
				OP_CHK_GPIO: begin
					#2;
					check_value("gpio_a_o", gpio_a_out, e.exp[3:0]);
					check_value("gpio_a_oe_o", gpio_a_oe, e.exp[7:4]);
					check_value("gpio_b_o", gpio_b_out, e.exp[11:8]);
					check_value("gpio_b_oe_o", gpio_b_oe, e.exp[15:12]);
				end
				default: ;
			endcase
		end
		report_test(cur_test);
		@(negedge clk);
		req = '0;

		$display("%0d tests, %0d checks, %0d errors", cur_test, check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: peri_subsystem.f
common/peri_pkg.sv
verilog/peri_bus_decoder.sv
verilog/peri_timer.sv
verilog/peri_irc.sv
verilog/peri_gpio.sv
verilog/peri_subsystem.sv
dv/peri_subsystem_tb.sv
